/* SlaveDaq.f */
+incdir+src
src/DaqPkg.sv
src/DaqCfgIf.sv
src/DaqRegisters.sv
src/AcqSequencer.sv
src/ReadoutPacker.sv
src/SlaveDaqTop.sv
bench/SlaveDaq_props.sv
bench/SlaveDaqBench.sv

/* bench/SlaveDaqBench.sv */
`timescale 1ns/1ps
`include "SlaveDaq_macros.svh"

module SlaveDaqBench;

    localparam int HoldTime = 6;   // End-hold time used for every cycle

    logic        Clk = 1'b0;
    logic        reset_n, CfgWrite, AcqStart, ChipSatB, EndReadout, AsicValid, OutCredit;
    logic [1:0]  CfgAddr;
    logic [15:0] CfgWData, CfgRData, AsicData, OutData;
    logic        ResetB, StartAcq, StartReadout, PwrOnA, PwrOnD, PwrOnDac, OnceEnd, OutValid;

    logic [31:0] Seed       = 32'h4aab766b;  // ASIC word stream
    logic [31:0] CreditSeed = 32'h4aab766b;  // Consumer delays
    logic [15:0] Expected[$];                // Words the consumer must see, in order
    int          Spent = 0;                  // Written at negedge only
    int          Returned = 0;               // Written at posedge only
    logic        HoldCredits = 1'b0;

    always #50 Clk = ~Clk;   // 100 ns period

    SlaveDaqTop i_SlaveDaqTop (.*);

    ////////////////////
    // Helpers
    function automatic logic [31:0] LfsrStep(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'hA3000000 : 32'h0);   // Galois taps 32,30,26,25
    endfunction

    task automatic RandBits(input int n, inout logic [31:0] st, output int v);
        v = 0;
        for (int k = 0; k < n; k++) begin
            v  = (v << 1) | int'(st[0]);   // One step per bit
            st = LfsrStep(st);
        end
    endtask

    // Reference keep rule, header marker in bit 15, hit pattern in bits 7:0
    function automatic bit ExpectedWords(input logic [15:0] w);
        if (w[15] || (w[7:0] != 8'h00)) begin
            Expected.push_back(w);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic Stop();
        $display("Checks failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic Check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            Stop();
        end
    endtask

    function automatic logic Sel(input int which);
        case (which)
            0:       return StartAcq;
            1:       return StartReadout;
            2:       return OnceEnd;
            default: return !ResetB;    // Reset low reads as active
        endcase
    endfunction

    task automatic WaitSig(input int which, input logic lvl, input string name);
        int n;
        n = 0;
        while (Sel(which) !== lvl) begin
            @(negedge Clk);
            n++;
            if (n > 5000) begin
                $display("Timeout while waiting for %s at %0t ns", name, $time);
                Stop();
            end
        end
    endtask

    task automatic CountHigh(input int which, input string name, output int len);
        len = 0;
        while (Sel(which) === 1'b1) begin
            len++;
            @(negedge Clk);
            if (len > 100000) begin
                $display("Pulse on %s never ended", name);
                Stop();
            end
        end
    endtask

    task automatic PulseLen(input int which, input string name, output int len);
        WaitSig(which, 1'b1, name);
        CountHigh(which, name, len);
    endtask

    task automatic WriteReg(input logic [1:0] addr, input logic [15:0] data);
        @(posedge Clk);
        CfgWrite <= 1'b1;
        CfgAddr  <= addr;
        CfgWData <= data;
        @(posedge Clk);
        CfgWrite <= 1'b0;
    endtask

    task automatic ReadReg(input logic [1:0] addr, output logic [15:0] data);
        @(posedge Clk);
        CfgAddr <= addr;
        @(negedge Clk);
        data = CfgRData;
    endtask

    // Header first, then hits; limit caps how many kept words are expected out
    task automatic EmitWords(input int nHits, input bit allHeaders, input int limit);
        logic [15:0] w;
        int          v;
        int          kept;
        kept = 0;
        for (int i = 0; i <= nHits; i++) begin
            if (i == 0 || allHeaders) begin
                RandBits(12, Seed, v);
                w = {1'b1, 3'd2, v[11:0]};
            end else begin
                RandBits(15, Seed, v);
                w = {1'b0, v[14:0]};
                RandBits(2, Seed, v);
                if (v == 0)
                    w[7:0] = 8'h00;   // Empty hit, must be dropped
            end
            if (kept < limit)
                kept += int'(ExpectedWords(w));
            @(posedge Clk);
            AsicValid <= 1'b1;
            AsicData  <= w;
        end
        @(posedge Clk);
        AsicValid <= 1'b0;
    endtask

    // One full ASIC cycle from trigger to end hold
    task automatic RunCycle(input int acqTime, input bit early, input int nHits);
        int          len;
        logic [15:0] rd;
        WriteReg(2'd1, 16'(acqTime));
        ReadReg(2'd1, rd);
        Check("CfgRData acquisition time", 32'(rd), acqTime);
        @(posedge Clk);
        AcqStart <= 1'b1;
        fork
            PulseLen(0, "StartAcq", len);
            if (early) begin
                repeat (3) @(posedge Clk);
                ChipSatB <= 1'b0;   // Chip full before the window ends
            end
        join
        if (early)
            Check("StartAcq ended early", 32'(len < acqTime + 1), 1);
        else
            Check("StartAcq length", len, acqTime + 1);
        @(posedge Clk);
        AcqStart <= 1'b0;
        ChipSatB <= 1'b0;
        repeat (3) @(posedge Clk);
        ChipSatB <= 1'b1;           // Chip released, readout may start
        PulseLen(1, "StartReadout", len);
        Check("StartReadout length", len, `DAQ_T_SRO + 1);
        EmitWords(nHits, 1'b0, 1000);
        @(posedge Clk);
        EndReadout <= 1'b1;
        repeat (3) @(posedge Clk);
        EndReadout <= 1'b0;
        PulseLen(2, "OnceEnd", len);
        Check("OnceEnd length", len, HoldTime + 1);
    endtask

    task automatic DrainStream();
        int n;
        n = 0;
        while (Expected.size() != 0 || Spent != Returned) begin
            @(negedge Clk);
            n++;
            if (n > 5000) begin
                $display("Output stream did not drain, %0d words missing", Expected.size());
                Stop();
            end
        end
    endtask

    ////////////////////
    // Credit consumer and output compare
    always @(posedge Clk) begin : creditReturn
        int v;
        RandBits(2, CreditSeed, v);
        if (reset_n && !HoldCredits && Spent != Returned && v == 0) begin
            OutCredit <= 1'b1;
            Returned  <= Returned + 1;
        end else begin
            OutCredit <= 1'b0;
        end
    end

    always @(negedge Clk) begin
        if (reset_n && OutValid) begin
            Spent++;
            if (Expected.size() == 0) begin
                $display("Output word %0h sent when none was expected", OutData);
                Stop();
            end else begin
                Check("OutData", 32'(OutData), 32'(Expected.pop_front()));
            end
        end
    end

    ////////////////////
    // Main sequence
    initial begin
        int          len;
        logic [15:0] rd;
        reset_n = 1'b0;
        CfgWrite = 1'b0;
        CfgAddr = 2'd0;
        CfgWData = '0;
        AcqStart = 1'b0;
        ChipSatB = 1'b1;
        EndReadout = 1'b0;
        AsicValid = 1'b0;
        AsicData = '0;
        OutCredit = 1'b0;
        repeat (10) @(posedge Clk);
        reset_n <= 1'b1;
        @(negedge Clk);
        Check("ResetB", 32'(ResetB), 1);
        Check("StartAcq", 32'(StartAcq), 0);
        Check("StartReadout", 32'(StartReadout), 0);
        Check("OnceEnd", 32'(OnceEnd), 0);
        Check("PwrOnA", 32'(PwrOnA), 0);
        Check("PwrOnD", 32'(PwrOnD), 0);
        Check("PwrOnDac", 32'(PwrOnDac), 0);
        Check("OutValid", 32'(OutValid), 0);

        WriteReg(2'd2, 16'(HoldTime));
        WriteReg(2'd0, 16'd1);
        WaitSig(3, 1'b1, "ResetB low");
        Check("PwrOnA", 32'(PwrOnA), 1);   // Analogue up first
        Check("PwrOnDac", 32'(PwrOnDac), 1);
        Check("PwrOnD", 32'(PwrOnD), 0);
        CountHigh(3, "ResetB low", len);
        Check("ResetB low length", len, `DAQ_T_POWER_RESET + 2);
        repeat (`DAQ_T_RESET_START + 5) @(posedge Clk);   // Release settling

        RunCycle(12, 1'b0, 10);
        RunCycle(30, 1'b0, 14);
        RunCycle(20, 1'b1, 12);
        DrainStream();
        ReadReg(2'd3, rd);
        Check("CfgRData acquisition count", 32'(rd), 3);

        // Back-pressure, 4 go out on initial credit, 8 fill the buffer
        HoldCredits = 1'b1;
        EmitWords(16, 1'b1, `DAQ_CREDITS + `DAQ_FIFO_DEPTH);
        ReadReg(2'd0, rd);
        Check("CfgRData overflow bit", 32'(rd[1]), 1);
        WriteReg(2'd0, 16'd3);        // Clear overflow, keep run on
        ReadReg(2'd0, rd);
        Check("CfgRData overflow bit", 32'(rd[1]), 0);
        HoldCredits = 1'b0;
        DrainStream();

        WriteReg(2'd0, 16'd0);
        repeat (4) @(posedge Clk);
        @(negedge Clk);
        Check("PwrOnA", 32'(PwrOnA), 0);
        Check("PwrOnD", 32'(PwrOnD), 0);
        Check("PwrOnDac", 32'(PwrOnDac), 0);

        $display("All checks passed");
        $finish;
    end

endmodule

/* bench/SlaveDaq_props.sv */
`timescale 1ns/1ps
`include "SlaveDaq_macros.svh"

module SlaveDaqProps (
    input logic Clk,
    input logic reset_n,
    input logic ResetB,
    input logic StartAcq,
    input logic PwrOnA,
    input logic PwrOnD,
    input logic OutValid,
    input logic OutCredit
);

    int Outstanding;   // Words sent and not yet credited back

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n)
            Outstanding <= 0;
        else
            Outstanding <= Outstanding + int'(OutValid) - int'(OutCredit);
    end

    ////////////////////
    // Protocol rules
    StartAcqInReset: assert property (@(posedge Clk) disable iff (!reset_n)
        StartAcq |-> ResetB) else $error("StartAcq high with ResetB low");

    DigitalNeedsAnalogue: assert property (@(posedge Clk) disable iff (!reset_n)
        PwrOnD |-> PwrOnA) else $error("PwrOnD without PwrOnA");

    CreditLimit: assert property (@(posedge Clk) disable iff (!reset_n)
        OutValid |-> (Outstanding < `DAQ_CREDITS)) else $error("OutValid without credit");

endmodule

bind SlaveDaqTop SlaveDaqProps i_SlaveDaqProps (.*);

/* run_sim.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f SlaveDaq.f --top-module SlaveDaqBench -o simv \
    > build.log 2>&1 && ./obj_dir/simv > sim.log 2>&1
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* src/AcqSequencer.sv */
`timescale 1ns/1ps
`include "SlaveDaq_macros.svh"

module AcqSequencer import DaqPkg::*; (
    input  logic Clk,
    input  logic reset_n,
    input  logic AcqStart,       // External trigger, asynchronous
    input  logic ChipSatB,       // Chip full, active low, asynchronous
    input  logic EndReadout,     // End of digital RAM readout, active high
    output logic ResetB,         // ASIC digital reset, active low
    output logic StartAcq,       // Acquisition window
    output logic StartReadout,   // Readout start pulse
    output logic PwrOnA,         // Analogue power pulsing
    output logic PwrOnD,         // Digital power pulsing
    output logic PwrOnDac,       // DAC power pulsing
    output logic OnceEnd,        // End of one acquisition cycle
    DaqCfgIf.Seq Cfg
);

    localparam logic [`DAQ_TIME_W-1:0] TPowerReset = `DAQ_TIME_W'(`DAQ_T_POWER_RESET);
    localparam logic [`DAQ_TIME_W-1:0] TResetStart = `DAQ_TIME_W'(`DAQ_T_RESET_START);
    localparam logic [`DAQ_TIME_W-1:0] TSro        = `DAQ_TIME_W'(`DAQ_T_SRO);

    ////////////////////
    // Input synchronizers
    // Bits 0 and 1 synchronize, bit 2 is the previous value for edge detect
    logic [2:0] AcqStartSync;
    logic [2:0] ChipSatBSync;
    logic [2:0] EndReadoutSync;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            AcqStartSync   <= 3'b000;
            ChipSatBSync   <= 3'b111;   // Idle level of ChipSatB is high
            EndReadoutSync <= 3'b000;
        end else begin
            AcqStartSync   <= {AcqStartSync[1:0], AcqStart};
            ChipSatBSync   <= {ChipSatBSync[1:0], ChipSatB};
            EndReadoutSync <= {EndReadoutSync[1:0], EndReadout};
        end
    end

    logic TrigRise;    // Trigger arrived
    logic ChipFull;    // ChipSatB falling, some chip memory full
    logic ReadReady;   // ChipSatB rising, readout may start
    logic EndRead;     // EndReadout falling

    assign TrigRise  =  AcqStartSync[1] & ~AcqStartSync[2];
    assign ChipFull  = ~ChipSatBSync[1] &  ChipSatBSync[2];
    assign ReadReady =  ChipSatBSync[1] & ~ChipSatBSync[2];
    assign EndRead   = ~EndReadoutSync[1] & EndReadoutSync[2];

    ////////////////////
    // Acquisition FSM
    SeqState_e              State;
    logic [`DAQ_TIME_W-1:0] DelayCount;   // Shared by every timed state, zero on entry

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            State            <= Idle;
            DelayCount       <= '0;
            Cfg.OnceEndPulse <= 1'b0;
        end else begin
            Cfg.OnceEndPulse <= 1'b0;
            case (State)
                Idle:
                    if (Cfg.RunEnable)
                        State <= ChipReset;
                ChipReset: State <= PowerOn;      // Power comes up, reset held
                PowerOn: begin
                    if (DelayCount < TPowerReset) begin
                        DelayCount <= DelayCount + 1'b1;
                    end else begin
                        DelayCount <= '0;
                        State      <= Release;    // ResetB released here
                    end
                end
                Release: begin
                    if (DelayCount < TResetStart) begin
                        DelayCount <= DelayCount + 1'b1;
                    end else begin
                        DelayCount <= '0;
                        State      <= WaitStart;
                    end
                end
                WaitStart: begin
                    if (!Cfg.RunEnable)
                        State <= AllDone;         // Run stopped, power down
                    else if (TrigRise)
                        State <= Acquire;
                end
                Acquire: begin
                    // Window ends on time out or on a full chip
                    if (DelayCount >= Cfg.AcquisitionTime || ChipFull) begin
                        DelayCount <= '0;
                        State      <= WaitRead;
                    end else begin
                        DelayCount <= DelayCount + 1'b1;
                    end
                end
                WaitRead:
                    if (ReadReady)
                        State <= StartRead;
                StartRead: begin
                    if (DelayCount < TSro) begin
                        DelayCount <= DelayCount + 1'b1;
                    end else begin
                        DelayCount <= '0;
                        State      <= WaitReadDone;
                    end
                end
                WaitReadDone: begin
                    if (EndRead) begin
                        State            <= DaqPkg::OnceEnd;  // Port of same name hides it
                        Cfg.OnceEndPulse <= 1'b1;             // Counted by the registers
                    end
                end
                DaqPkg::OnceEnd: begin
                    if (DelayCount < Cfg.EndHoldTime) begin
                        DelayCount <= DelayCount + 1'b1;
                    end else begin
                        DelayCount <= '0;
                        State      <= WaitStart;  // Re-arm, chip stays powered
                    end
                end
                AllDone: State <= Idle;
                default: State <= Idle;
            endcase
        end
    end

    ////////////////////
    // Outputs decoded from state
    assign ResetB       = !(State inside {ChipReset, PowerOn});
    assign StartAcq     = (State == Acquire);
    assign StartReadout = (State == StartRead);
    assign OnceEnd      = (State == DaqPkg::OnceEnd);

    // Analogue and DAC come up one cycle before digital
    assign PwrOnA   = State inside {ChipReset, PowerOn, Release, WaitStart, Acquire,
                                    WaitRead, StartRead, WaitReadDone, DaqPkg::OnceEnd};
    assign PwrOnDac = PwrOnA;
    assign PwrOnD   = State inside {PowerOn, Release, WaitStart, Acquire,
                                    WaitRead, StartRead, WaitReadDone, DaqPkg::OnceEnd};

endmodule

/* src/DaqCfgIf.sv */
`timescale 1ns/1ps
`include "SlaveDaq_macros.svh"

// Configuration down to the sequencer and packer, status back to the registers
interface DaqCfgIf;
    logic                   RunEnable;        // Level, run the ASIC cycle
    logic [`DAQ_TIME_W-1:0] AcquisitionTime;  // StartAcq length minus one
    logic [`DAQ_TIME_W-1:0] EndHoldTime;      // OnceEnd length minus one
    logic                   OnceEndPulse;     // One cycle per completed acquisition
    logic                   Overflow;         // One cycle per dropped word

    modport Regs (
        output RunEnable, AcquisitionTime, EndHoldTime,
        input  OnceEndPulse, Overflow
    );

    modport Seq (
        input  RunEnable, AcquisitionTime, EndHoldTime,
        output OnceEndPulse
    );

    modport Pack (
        output Overflow
    );
endinterface

/* src/DaqPkg.sv */
package DaqPkg;

    ////////////////////
    // ASIC readout word

    // Header word, marker set
    typedef struct packed {
        logic        Marker;       // 1 for header
        logic [2:0]  ChipId;       // Source chip on the chain
        logic [11:0] EventNumber;  // Acquisition number inside the chip
    } AsicHeader_s;

    // Hit word, marker clear
    typedef struct packed {
        logic       Marker;        // 0 for hit
        logic [5:0] Channel;
        logic       Gain;          // Gain range bit
        logic [7:0] HitPattern;    // One bit per memory column, zero means nothing hit
    } AsicHit_s;

    // Same 16 bits, two decodings
    typedef union packed {
        AsicHeader_s Header;
        AsicHit_s    Hit;
    } AsicWord_u;

    ////////////////////
    // Sequencer states, in cycle order
    typedef enum logic [3:0] {
        Idle, ChipReset, PowerOn, Release, WaitStart, Acquire,
        WaitRead, StartRead, WaitReadDone, OnceEnd, AllDone
    } SeqState_e;

endpackage

/* src/DaqRegisters.sv */
`timescale 1ns/1ps
`include "SlaveDaq_macros.svh"

module DaqRegisters (
    input  logic                   Clk,
    input  logic                   reset_n,
    input  logic                   CfgWrite,   // Single cycle write strobe
    input  logic [1:0]             CfgAddr,
    input  logic [`DAQ_TIME_W-1:0] CfgWData,
    output logic [`DAQ_TIME_W-1:0] CfgRData,   // Combinational from CfgAddr
    DaqCfgIf.Regs                  Cfg
);

    logic                   RunEnableReg;
    logic                   OverflowFlag;   // Sticky, cleared by software
    logic [`DAQ_TIME_W-1:0] AcqTimeReg;
    logic [`DAQ_TIME_W-1:0] HoldTimeReg;
    logic [`DAQ_TIME_W-1:0] AcqCount;       // Completed acquisitions, wraps

    ////////////////////
    // Write side
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            RunEnableReg <= 1'b0;
            OverflowFlag <= 1'b0;
            AcqTimeReg   <= `DAQ_TIME_W'(`DAQ_ACQ_TIME_RST);
            HoldTimeReg  <= `DAQ_TIME_W'(`DAQ_HOLD_TIME_RST);
            AcqCount     <= '0;
        end else begin
            if (CfgWrite) begin
                case (CfgAddr)
                    2'd0: begin
                        RunEnableReg <= CfgWData[0];
                        if (CfgWData[1])
                            OverflowFlag <= 1'b0;  // Write one to clear
                    end
                    2'd1: AcqTimeReg  <= CfgWData;
                    2'd2: HoldTimeReg <= CfgWData;
                    default: ;                     // Count is read only
                endcase
            end
            // New overflow wins over a clear in the same cycle
            if (Cfg.Overflow)
                OverflowFlag <= 1'b1;
            if (Cfg.OnceEndPulse)
                AcqCount <= AcqCount + 1'b1;
        end
    end

    assign Cfg.RunEnable       = RunEnableReg;
    assign Cfg.AcquisitionTime = AcqTimeReg;
    assign Cfg.EndHoldTime     = HoldTimeReg;

    ////////////////////
    // Read mux
    always_comb begin
        case (CfgAddr)
            2'd0:    CfgRData = {{(`DAQ_TIME_W-2){1'b0}}, OverflowFlag, RunEnableReg};
            2'd1:    CfgRData = AcqTimeReg;
            2'd2:    CfgRData = HoldTimeReg;
            default: CfgRData = AcqCount;
        endcase
    end

endmodule

/* src/ReadoutPacker.sv */
`timescale 1ns/1ps
`include "SlaveDaq_macros.svh"

module ReadoutPacker import DaqPkg::*; (
    input  logic                   Clk,
    input  logic                   reset_n,
    input  logic                   AsicValid,   // ASIC word strobe, cannot be stalled
    input  logic [`DAQ_WORD_W-1:0] AsicData,
    input  logic                   OutCredit,   // One credit back per cycle
    output logic                   OutValid,
    output logic [`DAQ_WORD_W-1:0] OutData,
    DaqCfgIf.Pack                  Cfg
);

    localparam int PtrW    = $clog2(`DAQ_FIFO_DEPTH);
    localparam int CreditW = $clog2(`DAQ_CREDITS + 1);
    localparam logic [CreditW-1:0] MaxCredits = CreditW'(`DAQ_CREDITS);

    ////////////////////
    // Input register and keep decision
    logic      InValid;
    AsicWord_u InWord;
    logic      Keep;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n)
            InValid <= 1'b0;
        else
            InValid <= AsicValid;
    end

    always_ff @(posedge Clk) begin
        if (AsicValid)
            InWord <= AsicData;
    end

    // Headers always kept, hits only with something in the pattern
    assign Keep = InWord.Header.Marker || (InWord.Hit.HitPattern != '0);

    ////////////////////
    // Circular buffer, pointers carry one wrap bit
    logic [`DAQ_WORD_W-1:0] Mem [`DAQ_FIFO_DEPTH];
    logic [PtrW:0]          WrPtr;
    logic [PtrW:0]          RdPtr;
    logic [CreditW-1:0]     Credits;
    logic                   Empty, Full, Push, Pop;

    assign Empty = (WrPtr == RdPtr);
    assign Full  = (WrPtr[PtrW] != RdPtr[PtrW]) && (WrPtr[PtrW-1:0] == RdPtr[PtrW-1:0]);
    assign Pop   = OutValid;
    assign Push  = InValid && Keep && (!Full || Pop);  // Slot freed by a pop is reusable

    assign Cfg.Overflow = InValid && Keep && Full && !Pop;  // Word is lost

    always_ff @(posedge Clk) begin
        if (Push)
            Mem[WrPtr[PtrW-1:0]] <= InWord;
    end

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            WrPtr   <= '0;
            RdPtr   <= '0;
            Credits <= MaxCredits;   // Consumer starts empty
        end else begin
            if (Push)
                WrPtr <= WrPtr + 1'b1;
            if (Pop)
                RdPtr <= RdPtr + 1'b1;
            case ({Pop, OutCredit})
                2'b10:   Credits <= Credits - 1'b1;
                2'b01:   if (Credits != MaxCredits) Credits <= Credits + 1'b1;  // Saturate
                default: ;           // Spend and return cancel
            endcase
        end
    end

    ////////////////////
    // Send side, gated by credit
    assign OutValid = !Empty && (Credits != '0);
    assign OutData  = Mem[RdPtr[PtrW-1:0]];

endmodule

/* src/SlaveDaqTop.sv */
`timescale 1ns/1ps
`include "SlaveDaq_macros.svh"

module SlaveDaqTop (
    input  logic                   Clk,
    input  logic                   reset_n,
    // Config bus
    input  logic                   CfgWrite,
    input  logic [1:0]             CfgAddr,
    input  logic [`DAQ_TIME_W-1:0] CfgWData,
    output logic [`DAQ_TIME_W-1:0] CfgRData,
    // ASIC control and readout
    input  logic                   AcqStart,
    input  logic                   ChipSatB,
    input  logic                   EndReadout,
    input  logic                   AsicValid,
    input  logic [`DAQ_WORD_W-1:0] AsicData,
    output logic                   ResetB,
    output logic                   StartAcq,
    output logic                   StartReadout,
    output logic                   PwrOnA,
    output logic                   PwrOnD,
    output logic                   PwrOnDac,
    output logic                   OnceEnd,
    // Output stream
    output logic                   OutValid,
    output logic [`DAQ_WORD_W-1:0] OutData,
    input  logic                   OutCredit
);

    DaqCfgIf CfgBus ();   // Registers to sequencer and packer

    DaqRegisters i_DaqRegisters (
        .Clk, .reset_n, .CfgWrite, .CfgAddr, .CfgWData, .CfgRData,
        .Cfg (CfgBus.Regs)
    );

    AcqSequencer i_AcqSequencer (
        .Clk, .reset_n, .AcqStart, .ChipSatB, .EndReadout,
        .ResetB, .StartAcq, .StartReadout, .PwrOnA, .PwrOnD, .PwrOnDac, .OnceEnd,
        .Cfg (CfgBus.Seq)
    );

    ReadoutPacker i_ReadoutPacker (
        .Clk, .reset_n, .AsicValid, .AsicData, .OutCredit, .OutValid, .OutData,
        .Cfg (CfgBus.Pack)
    );

endmodule

/* src/SlaveDaq_macros.svh */
`ifndef SLAVEDAQ_MACROS_SVH
`define SLAVEDAQ_MACROS_SVH

// Datapath widths
`define DAQ_TIME_W 16           // Time and count registers
`define DAQ_WORD_W 16           // One ASIC readout word

// ASIC timing minimums, in Clk cycles
`define DAQ_T_POWER_RESET 8     // Wake up the LVDS clock receivers
`define DAQ_T_RESET_START 40    // Internal settling after reset release
`define DAQ_T_SRO 16            // Length of the readout start pulse

// Register reset values
`define DAQ_ACQ_TIME_RST 8
`define DAQ_HOLD_TIME_RST 4

// Output stream
`define DAQ_CREDITS 4           // Consumer buffer depth, also initial credit
`define DAQ_FIFO_DEPTH 8        // Packer buffer, power of two

`endif
